//--- blinky_pkg.sv
package blinky_pkg;

  // ----------------------------------------------------------------------
  // system constants
  // ----------------------------------------------------------------------

  // clock frequency in cycles per second, returned by register 0x02
  localparam logic [31:0] clk_freq = 32'd100_000_000;

  // toggle count after reset gives a 1 Hz blink at clk_freq
  localparam logic [31:0] default_cnt_toggle = clk_freq / 2;

  // ----------------------------------------------------------------------
  // register map
  // ----------------------------------------------------------------------

  // word addresses on the 8-bit AXI-Lite address
  localparam logic [7:0] addr_flags      = 8'h00;
  localparam logic [7:0] addr_cnt_toggle = 8'h01;
  localparam logic [7:0] addr_clk_freq   = 8'h02;
  localparam logic [7:0] addr_cnt        = 8'h03;

  // AXI-Lite response codes
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axil_resp_t;

  // ----------------------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------------------

  // write address channel
  typedef struct packed {
    logic [7:0] addr;
  } axil_aw_t;

  // write data channel with byte strobes
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  // read address channel
  typedef struct packed {
    logic [7:0] addr;
  } axil_ar_t;

  // control register state shared by write path, read path and blinker
  typedef struct packed {
    logic        enable;
    logic        blink;
    logic [31:0] cnt_toggle;
  } blink_ctrl_t;

  // live counter value
  typedef logic [31:0] cnt_t;

endpackage

//--- skid_buffer.sv
module skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  // upstream side
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  // downstream side
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  // second slot catches the item that arrives while the output stalls
  logic     skid_valid;
  payload_t skid_data;

  // main register can take a new item this cycle
  logic     out_free;

  assign out_free = !o_valid || i_ready;

  // upstream ready comes straight from a flop
  assign o_ready = !skid_valid;

  // ----------------------------------------------------------------------
  // valid flags
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      if (skid_valid) begin
        // drain the skid slot first to keep ordering
        o_valid    <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        o_valid <= i_valid;
      end
    end else if (i_valid && o_ready) begin
      // output stalled so park the incoming item
      skid_valid <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // payload registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (out_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (!out_free && i_valid && o_ready) begin
      skid_data <= i_data;
    end
  end

  // output item holds until taken
  a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

  // skid slot only fills behind a full main slot so an empty buffer is ready
  a_empty_ready : assert property (@(posedge clk) disable iff (!rst_n)
    !o_valid |-> o_ready);

endmodule

//--- pipelined_counter.sv
module pipelined_counter
  import blinky_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_clr,
  output cnt_t o_cnt
);

  // ----------------------------------------------------------------------
  // two 16-bit halves with a registered carry between them
  // ----------------------------------------------------------------------

  // low half of the internal count
  logic [15:0] cnt_lo;
  // carry out of the low half, applied to the high half one cycle late
  logic        carry;
  // high half, lines up with the low half of the previous cycle
  logic [15:0] cnt_hi;
  // low half delayed so both halves describe the same count
  logic [15:0] cnt_lo_d;

  always_ff @(posedge clk) begin
    if (!rst_n || i_clr) begin
      cnt_lo   <= '0;
      carry    <= 1'b0;
      cnt_hi   <= '0;
      cnt_lo_d <= '0;
    end else begin
      // 17-bit sum keeps the carry out of the low half
      {carry, cnt_lo} <= {1'b0, cnt_lo} + 17'd1;
      // high half only ever sees a registered one-bit carry
      cnt_hi          <= cnt_hi + {15'd0, carry};
      cnt_lo_d        <= cnt_lo;
    end
  end

  // coherent count, one cycle behind the internal low half
  assign o_cnt = {cnt_hi, cnt_lo_d};

  // free running count steps by one once two clear-free cycles have passed
  a_step_one : assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) && !i_clr && !$past(i_clr) |=> o_cnt == cnt_t'($past(o_cnt) + 32'd1));

endmodule

//--- led_blinker.sv
module led_blinker
  import blinky_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  blink_ctrl_t i_ctrl,
  output cnt_t        o_cnt,
  output logic        o_led
);

  // ----------------------------------------------------------------------
  // counter control
  // ----------------------------------------------------------------------

  // counter reached the programmed toggle point
  logic cnt_hit;
  // hold or restart the counter
  logic cnt_clr;

  assign cnt_hit = (o_cnt == i_ctrl.cnt_toggle);

  // counter only runs in blink mode and restarts on every hit
  assign cnt_clr = !i_ctrl.enable || !i_ctrl.blink || cnt_hit;

  pipelined_counter u_pipelined_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .i_clr (cnt_clr),
    .o_cnt (o_cnt)
  );

  // ----------------------------------------------------------------------
  // led state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_led <= 1'b0;
    end else if (!i_ctrl.enable) begin
      // disabled
      o_led <= 1'b0;
    end else if (!i_ctrl.blink) begin
      // solid on
      o_led <= 1'b1;
    end else if (cnt_hit) begin
      // blink on each counter match
      o_led <= ~o_led;
    end
  end

  // disabling the blinker darkens the led on the next cycle
  a_led_off : assert property (@(posedge clk) disable iff (!rst_n)
    !i_ctrl.enable |=> !o_led);

endmodule

//--- axil_write_path.sv
module axil_write_path
  import blinky_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // write address from skid buffer
  input  logic        i_aw_valid,
  input  axil_aw_t    i_aw,
  output logic        o_aw_ready,
  // write data from skid buffer
  input  logic        i_w_valid,
  input  axil_w_t     i_w,
  output logic        o_w_ready,
  // write response
  output logic        o_bvalid,
  output axil_resp_t  o_bresp,
  input  logic        i_bready,
  // control registers
  output blink_ctrl_t o_ctrl
);

  logic        wr_accept;
  logic        bvalid_next;
  axil_resp_t  bresp_next;
  blink_ctrl_t ctrl_next;

  // AW and W go together and only when the B slot is free or draining
  assign wr_accept  = i_aw_valid && i_w_valid && (!o_bvalid || i_bready);
  assign o_aw_ready = wr_accept;
  assign o_w_ready  = wr_accept;

  // ----------------------------------------------------------------------
  // write decode
  // ----------------------------------------------------------------------

  always_comb begin
    // pending response drops once bready takes it
    bvalid_next = o_bvalid && !i_bready;
    bresp_next  = o_bresp;
    ctrl_next   = o_ctrl;

    if (wr_accept) begin
      bvalid_next = 1'b1;
      bresp_next  = resp_okay;
      case (i_aw.addr)
        addr_flags: begin
          if (i_w.strb != 4'hf) begin
            bresp_next = resp_slverr;
          end else begin
            // upper flag bits are dropped
            ctrl_next.enable = i_w.data[0];
            ctrl_next.blink  = i_w.data[1];
          end
        end
        addr_cnt_toggle: begin
          if (i_w.strb != 4'hf) begin
            bresp_next = resp_slverr;
          end else begin
            ctrl_next.cnt_toggle = i_w.data;
          end
        end
        // read-only registers
        addr_clk_freq, addr_cnt: bresp_next = resp_slverr;
        // nothing mapped here
        default: bresp_next = resp_decerr;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // B response and control registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bvalid <= 1'b0;
      o_ctrl   <= '{enable: 1'b0, blink: 1'b0, cnt_toggle: default_cnt_toggle};
    end else begin
      o_bvalid <= bvalid_next;
      o_ctrl   <= ctrl_next;
    end
  end

  always_ff @(posedge clk) begin
    o_bresp <= bresp_next;
  end

  // a raised response waits for the master
  a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

endmodule

//--- axil_read_path.sv
module axil_read_path
  import blinky_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // read address from skid buffer
  input  logic        i_ar_valid,
  input  axil_ar_t    i_ar,
  output logic        o_ar_ready,
  // register sources
  input  blink_ctrl_t i_ctrl,
  input  cnt_t        i_cnt,
  // read response
  output logic        o_rvalid,
  output logic [31:0] o_rdata,
  output axil_resp_t  o_rresp,
  input  logic        i_rready
);

  logic        rd_accept;
  logic        rvalid_next;
  logic [31:0] rdata_next;
  axil_resp_t  rresp_next;

  // take a read when no R is pending or the pending R leaves this cycle
  assign rd_accept  = i_ar_valid && (!o_rvalid || i_rready);
  assign o_ar_ready = rd_accept;

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------

  always_comb begin
    rvalid_next = o_rvalid && !i_rready;
    rdata_next  = o_rdata;
    rresp_next  = o_rresp;

    if (rd_accept) begin
      rvalid_next = 1'b1;
      rresp_next  = resp_okay;
      case (i_ar.addr)
        // flags come back zero extended
        addr_flags:      rdata_next = {30'd0, i_ctrl.blink, i_ctrl.enable};
        addr_cnt_toggle: rdata_next = i_ctrl.cnt_toggle;
        addr_clk_freq:   rdata_next = clk_freq;
        // counter sampled in the accept cycle
        addr_cnt:        rdata_next = i_cnt;
        default: begin
          rdata_next = '0;
          rresp_next = resp_decerr;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // R response registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= rvalid_next;
    end
  end

  always_ff @(posedge clk) begin
    o_rdata <= rdata_next;
    o_rresp <= rresp_next;
  end

  // stalled read data stays put
  a_r_stable : assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

//--- blinky_reg_top.sv
module blinky_reg_top
  import blinky_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  output logic        o_led,
  // write address channel
  input  logic [7:0]  i_awaddr,
  input  logic        i_awvalid,
  output logic        o_awready,
  // write data channel
  input  logic [31:0] i_wdata,
  input  logic [3:0]  i_wstrb,
  input  logic        i_wvalid,
  output logic        o_wready,
  // write response channel
  output logic        o_bvalid,
  output logic [1:0]  o_bresp,
  input  logic        i_bready,
  // read address channel
  input  logic [7:0]  i_araddr,
  input  logic        i_arvalid,
  output logic        o_arready,
  // read data channel
  output logic        o_rvalid,
  output logic [31:0] o_rdata,
  output logic [1:0]  o_rresp,
  input  logic        i_rready
);

  // ----------------------------------------------------------------------
  // channel bundles
  // ----------------------------------------------------------------------

  // raw AXI-Lite signals packed into channel structs
  axil_aw_t    aw_in;
  axil_w_t     w_in;
  axil_ar_t    ar_in;

  // skid buffer outputs
  axil_aw_t    aw_sb;
  logic        aw_sb_valid;
  logic        aw_sb_ready;
  axil_w_t     w_sb;
  logic        w_sb_valid;
  logic        w_sb_ready;
  axil_ar_t    ar_sb;
  logic        ar_sb_valid;
  logic        ar_sb_ready;

  // responses and shared state
  axil_resp_t  bresp;
  axil_resp_t  rresp;
  blink_ctrl_t ctrl;
  cnt_t        cnt;

  assign aw_in.addr = i_awaddr;
  assign w_in.data  = i_wdata;
  assign w_in.strb  = i_wstrb;
  assign ar_in.addr = i_araddr;
  assign o_bresp    = bresp;
  assign o_rresp    = rresp;

  // ----------------------------------------------------------------------
  // input skid buffers
  // ----------------------------------------------------------------------

  skid_buffer #(.payload_t(axil_aw_t)) u_skid_aw (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_awvalid),
    .i_data  (aw_in),
    .o_ready (o_awready),
    .o_valid (aw_sb_valid),
    .o_data  (aw_sb),
    .i_ready (aw_sb_ready)
  );

  skid_buffer #(.payload_t(axil_w_t)) u_skid_w (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_wvalid),
    .i_data  (w_in),
    .o_ready (o_wready),
    .o_valid (w_sb_valid),
    .o_data  (w_sb),
    .i_ready (w_sb_ready)
  );

  skid_buffer #(.payload_t(axil_ar_t)) u_skid_ar (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_arvalid),
    .i_data  (ar_in),
    .o_ready (o_arready),
    .o_valid (ar_sb_valid),
    .o_data  (ar_sb),
    .i_ready (ar_sb_ready)
  );

  // ----------------------------------------------------------------------
  // register paths and blinker
  // ----------------------------------------------------------------------

  axil_write_path u_axil_write_path (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_aw_valid (aw_sb_valid),
    .i_aw       (aw_sb),
    .o_aw_ready (aw_sb_ready),
    .i_w_valid  (w_sb_valid),
    .i_w        (w_sb),
    .o_w_ready  (w_sb_ready),
    .o_bvalid   (o_bvalid),
    .o_bresp    (bresp),
    .i_bready   (i_bready),
    .o_ctrl     (ctrl)
  );

  axil_read_path u_axil_read_path (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ar_valid (ar_sb_valid),
    .i_ar       (ar_sb),
    .o_ar_ready (ar_sb_ready),
    .i_ctrl     (ctrl),
    .i_cnt      (cnt),
    .o_rvalid   (o_rvalid),
    .o_rdata    (o_rdata),
    .o_rresp    (rresp),
    .i_rready   (i_rready)
  );

  led_blinker u_led_blinker (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_ctrl (ctrl),
    .o_cnt  (cnt),
    .o_led  (o_led)
  );

endmodule

//--- tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

  // ----------------------------------------------------------------------
  // counters and per-test bookkeeping
  // ----------------------------------------------------------------------

  int    err_count  = 0;
  int    test_count = 0;
  int    test_errs  = 0;
  // requests issued against B and R handshakes seen on the DUT ports
  int    req_count  = 0;
  int    resp_count = 0;
  // cycles any handshake wait may take
  int    wait_limit = 200;
  string test_name  = "none";

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    test_count++;
    $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "pass" : "fail",
             test_errs);
  endtask

  // count a failure against the running test
  task automatic note_error();
    err_count++;
    test_errs++;
  endtask

  task automatic report_timeout(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    note_error();
  endtask

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      note_error();
    end
  endtask

  // ----------------------------------------------------------------------
  // AXI-Lite master side
  // ----------------------------------------------------------------------

  // AW and W raised together, each dropped after its own handshake
  task automatic send_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int   t;
    logic aw_done;
    logic w_done;
    t       = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    req_count++;
    do begin
      // handshake seen at negedge completes on the next rising edge
      @(negedge clk);
      t++;
      aw_done = aw_done || (awvalid && awready);
      w_done  = w_done || (wvalid && wready);
      @(posedge clk);
      if (aw_done) awvalid <= 1'b0;
      if (w_done) wvalid <= 1'b0;
    end while (!(aw_done && w_done) && t < wait_limit);
    if (!(aw_done && w_done)) begin
      report_timeout("write address or data was never accepted");
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end
  endtask

  // wait for B, stall it for a while, then take it
  task automatic take_b(input int stall, output logic [1:0] resp);
    int t;
    t    = 0;
    resp = 2'bxx;
    do begin
      @(negedge clk);
      t++;
    end while (!bvalid && t < wait_limit);
    if (!bvalid) begin
      report_timeout("no write response arrived");
    end else begin
      repeat (stall) @(negedge clk);
      @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
      resp = bresp;
      @(posedge clk);
      bready <= 1'b0;
    end
  endtask

  task automatic send_read(input logic [7:0] addr);
    int   t;
    logic ar_done;
    t       = 0;
    ar_done = 1'b0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    req_count++;
    do begin
      @(negedge clk);
      t++;
      ar_done = arvalid && arready;
      @(posedge clk);
    end while (!ar_done && t < wait_limit);
    arvalid <= 1'b0;
    if (!ar_done) report_timeout("read address was never accepted");
  endtask

  task automatic take_r(input int stall, output logic [31:0] data, output logic [1:0] resp);
    int t;
    t    = 0;
    data = 'x;
    resp = 2'bxx;
    do begin
      @(negedge clk);
      t++;
    end while (!rvalid && t < wait_limit);
    if (!rvalid) begin
      report_timeout("no read response arrived");
    end else begin
      repeat (stall) @(negedge clk);
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      rready <= 1'b0;
    end
  endtask

`endif

//--- tb_blinky_reg.sv
module tb_blinky_reg
  import blinky_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        led;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  integer      seed;

  `include "tb_axil_tasks.svh"

  initial clk = 1'b0;
  always #20 clk = ~clk;

  blinky_reg_top i_blinky_reg_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .o_led     (led),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_bresp   (bresp),
    .i_bready  (bready),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .i_rready  (rready)
  );

  // ----------------------------------------------------------------------
  // handshake rules on the response channels
  // ----------------------------------------------------------------------

  a_b_hold : assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("ERROR %s: write response dropped or changed while bready was low", test_name);
      note_error();
    end

  a_r_hold : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("ERROR %s: read response dropped or changed while rready was low", test_name);
      note_error();
    end

  // every B and R handshake completed on the DUT ports
  always @(posedge clk) begin
    if (rst_n && bvalid && bready) begin
      resp_count++;
    end
    if (rst_n && rvalid && rready) begin
      resp_count++;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  function automatic int stall_len();
    return ($unsigned($random(seed)) % 8) + 1;
  endfunction

  task automatic check_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    send_write(addr, data, strb);
    take_b(0, resp);
    expect_eq("bresp", exp_resp, resp);
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    send_read(addr);
    take_r(0, data, resp);
    expect_eq("rdata", exp_data, data);
    expect_eq("rresp", exp_resp, resp);
  endtask

  // led must keep one level for a number of cycles
  task automatic hold_led(input logic exp, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      expect_eq("led", exp, led);
    end
  endtask

  task automatic wait_led_change(output int cycles);
    logic prev;
    @(negedge clk);
    prev   = led;
    // the negedge that takes prev is already one cycle past the last change
    cycles = 1;
    do begin
      @(negedge clk);
      cycles++;
    end while (led == prev && cycles < 100);
    if (led == prev) report_timeout("led did not toggle within 100 cycles");
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    int          gap;
    seed    = 32'h052a_56e8;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_values");
    check_read(addr_flags, 32'd0, resp_okay);
    check_read(addr_cnt_toggle, default_cnt_toggle, resp_okay);
    check_read(addr_clk_freq, clk_freq, resp_okay);
    hold_led(1'b0, 2);
    finish_test();

    // toggle count first so the counter never runs past it
    start_test("write_readback");
    check_write(addr_cnt_toggle, 32'd20, 4'hf, resp_okay);
    check_write(addr_flags, 32'hdead_bee3, 4'hf, resp_okay);
    check_read(addr_flags, 32'd3, resp_okay);
    check_read(addr_cnt_toggle, 32'd20, resp_okay);
    finish_test();

    start_test("error_responses");
    check_write(addr_flags, 32'd0, 4'h3, resp_slverr);
    check_read(addr_flags, 32'd3, resp_okay);
    check_write(addr_clk_freq, 32'd5, 4'hf, resp_slverr);
    check_read(addr_clk_freq, clk_freq, resp_okay);
    check_write(addr_cnt, 32'd7, 4'hf, resp_slverr);
    check_write(8'h10, 32'd9, 4'hf, resp_decerr);
    check_read(8'h10, 32'd0, resp_decerr);
    check_read(addr_cnt_toggle, 32'd20, resp_okay);
    finish_test();

    start_test("led_modes");
    check_write(addr_flags, 32'd0, 4'hf, resp_okay);
    hold_led(1'b0, 30);
    check_write(addr_flags, 32'd1, 4'hf, resp_okay);
    hold_led(1'b1, 30);
    check_write(addr_flags, 32'd3, 4'hf, resp_okay);
    // first change only syncs, the second one gives a full period
    wait_led_change(gap);
    wait_led_change(gap);
    assert (gap >= 20) else begin
      $display("ERROR %s toggle_gap: expected >= 20, actual %0d", test_name, gap);
      note_error();
    end
    send_read(addr_cnt);
    take_r(0, data, resp);
    expect_eq("cnt_rresp", resp_okay, resp);
    assert (data <= 32'd20) else begin
      $display("ERROR %s cnt: expected <= 20, actual %0d", test_name, data);
      note_error();
    end
    finish_test();

    // second request of each kind waits in the skid buffer behind a stalled one
    start_test("back_pressure");
    send_write(addr_cnt_toggle, 32'd30, 4'hf);
    send_write(addr_clk_freq, 32'd1, 4'hf);
    take_b(stall_len(), resp);
    expect_eq("bresp_1", resp_okay, resp);
    take_b(stall_len(), resp);
    expect_eq("bresp_2", resp_slverr, resp);
    send_read(addr_cnt_toggle);
    send_read(8'h10);
    take_r(stall_len(), data, resp);
    expect_eq("rdata_1", 32'd30, data);
    expect_eq("rresp_1", resp_okay, resp);
    take_r(stall_len(), data, resp);
    expect_eq("rdata_2", 32'd0, data);
    expect_eq("rresp_2", resp_decerr, resp);
    // last handshake lands in the response count before it is compared
    @(negedge clk);
    expect_eq("responses", req_count, resp_count);
    finish_test();

    $display("tests %0d, errors %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
blinky_pkg.sv
skid_buffer.sv
pipelined_counter.sv
led_blinker.sv
axil_write_path.sv
axil_read_path.sv
blinky_reg_top.sv
tb_blinky_reg.sv
